//--- Bender.yml
package:
  name: ghrd_core

sources:
  - hw/ghrd_pkg.sv
  - hw/key_debounce.sv
  - hw/reset_pulse_gen.sv
  - hw/boot_program_buffer.sv
  - hw/program_scanner.sv
  - hw/ghrd_core.sv
  - target: test
    files:
      - testbench/tb_ghrd_core.sv

//--- hw/boot_program_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module boot_program_buffer (
  input  wire logic                 fpga_clk_50,
  input  wire logic                 rst_n,
  input  wire logic                 wr_en,    // boot load strobe
  input  wire ghrd_pkg::prog_addr_t wr_addr,
  input  wire ghrd_pkg::prog_word_t wr_data,
  input  wire ghrd_pkg::prog_addr_t rd_addr,
  output ghrd_pkg::prog_word_t      rd_data   // one cycle after rd_addr
);

  import ghrd_pkg::*;

  localparam int DEPTH = 1 << PROG_ADDR_W;

  prog_word_t mem [DEPTH];  // program bytes

  // write port, last word wins
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      mem <= '{default: '0};  // empty program
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hw/ghrd_core.sv
`timescale 1ns/100ps
`default_nettype none

module ghrd_core #(
  parameter int DEBOUNCE_TICKS = 50000,      // 1 ms at 50 MHz
  parameter int SCAN_DIV       = 25_000_000  // two steps a second
) (
  input  wire logic                          fpga_clk_50,
  input  wire logic                          rst_n,
  input  wire logic [ghrd_pkg::NUM_KEYS-1:0] key,               // active low
  input  wire logic [3:0]                    sw,
  input  wire logic [2:0]                    reset_req,         // cold, warm, debug
  input  wire logic                          boot_loader_flag,  // low while loading
  input  wire ghrd_pkg::instr_word_t         instruction,
  output ghrd_pkg::prog_word_t               led,
  output logic                               hps_cold_reset,
  output logic                               hps_warm_reset,
  output logic                               hps_debug_reset
);

  import ghrd_pkg::*;

  // ====================
  // internal nets
  // ====================
  logic [NUM_KEYS-1:0] keys_pressed;
  logic                wr_en;
  prog_addr_t          wr_addr;
  prog_word_t          wr_data;
  prog_addr_t          rd_addr;
  prog_word_t          rd_data;

  assign wr_en   = ~boot_loader_flag;  // load mode
  assign wr_addr = instruction.addr;
  assign wr_data = instruction.data;

  // button cleanup
  key_debounce #(
    .WIDTH          (NUM_KEYS),
    .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
  ) key_debounce_inst (
    .fpga_clk_50  (fpga_clk_50),
    .rst_n        (rst_n),
    .key          (key),
    .keys_pressed (keys_pressed)
  );

  // ====================
  // reset request pulses
  // ====================
  reset_pulse_gen #(
    .PULSE_EXT (COLD_PULSE_CYCLES)
  ) pulse_cold_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .req         (reset_req[RESET_KIND_COLD]),
    .pulse       (hps_cold_reset)
  );

  reset_pulse_gen #(
    .PULSE_EXT (WARM_PULSE_CYCLES)
  ) pulse_warm_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .req         (reset_req[RESET_KIND_WARM]),
    .pulse       (hps_warm_reset)
  );

  reset_pulse_gen #(
    .PULSE_EXT (DEBUG_PULSE_CYCLES)
  ) pulse_debug_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .req         (reset_req[RESET_KIND_DEBUG]),
    .pulse       (hps_debug_reset)
  );

  // ====================
  // program path
  // ====================
  boot_program_buffer boot_buffer_inst (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  program_scanner #(
    .SCAN_DIV (SCAN_DIV)
  ) scanner_inst (
    .fpga_clk_50  (fpga_clk_50),
    .rst_n        (rst_n),
    .run          (boot_loader_flag),
    .show_program (sw[0]),           // program bytes vs status view
    .keys_pressed (keys_pressed),
    .cold_pulse   (hps_cold_reset),
    .warm_pulse   (hps_warm_reset),
    .debug_pulse  (hps_debug_reset),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .led          (led)
  );

endmodule

`default_nettype wire

//--- hw/ghrd_pkg.sv
`default_nettype none

package ghrd_pkg;

  // ====================
  // widths
  // ====================
  localparam int NUM_KEYS    = 2;  // two push buttons
  localparam int PROG_ADDR_W = 3;  // eight buffer entries
  localparam int PROG_DATA_W = 8;  // one byte per entry, same as the led bank

  typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
  typedef logic [PROG_DATA_W-1:0] prog_word_t;  // also the led type

  // boot word from the loader
  // address sits in the top three bits
  typedef struct packed {
    prog_addr_t addr;  // instruction[10:8]
    prog_word_t data;  // instruction[7:0]
  } instr_word_t;

  // ====================
  // reset requests
  // ====================
  localparam int COLD_PULSE_CYCLES  = 6;
  localparam int WARM_PULSE_CYCLES  = 2;
  localparam int DEBUG_PULSE_CYCLES = 32;

  // bit positions in reset_req
  localparam int RESET_KIND_COLD  = 0;
  localparam int RESET_KIND_WARM  = 1;
  localparam int RESET_KIND_DEBUG = 2;

endpackage

`default_nettype wire

//--- hw/key_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
  parameter int WIDTH          = 2,
  parameter int DEBOUNCE_TICKS = 50000  // 1 ms at 50 MHz
) (
  input  wire logic             fpga_clk_50,
  input  wire logic             rst_n,
  input  wire logic [WIDTH-1:0] key,          // raw buttons, active low
  output logic      [WIDTH-1:0] keys_pressed  // clean, active high
);

  // counter must reach DEBOUNCE_TICKS-1
  localparam int               CNT_W    = $clog2(DEBOUNCE_TICKS + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_TICKS - 1);

  for (genvar i = 0; i < WIDTH; i++) begin : g_key
    logic [1:0]       sync_q;      // two-flop sync, already inverted
    logic [CNT_W-1:0] stable_cnt;  // cycles the raw level disagreed
    logic             pressed_q;
    logic             differ;

    assign differ          = sync_q[1] ^ pressed_q;
    assign keys_pressed[i] = pressed_q;

    // ====================
    // synchronizer
    // ====================
    always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
      if (!rst_n) begin
        sync_q <= '0;  // released
      end else begin
        sync_q <= {sync_q[0], ~key[i]};
      end
    end

    // ====================
    // stability counter
    // ====================
    always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
      if (!rst_n) begin
        stable_cnt <= '0;
        pressed_q  <= 1'b0;
      end else if (!differ) begin
        stable_cnt <= '0;  // bounce back, start over
      end else if (stable_cnt == CNT_LAST) begin
        stable_cnt <= '0;
        pressed_q  <= sync_q[1];  // held long enough, take it
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/program_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module program_scanner #(
  parameter int SCAN_DIV = 25_000_000  // cycles per pointer step
) (
  input  wire logic                          fpga_clk_50,
  input  wire logic                          rst_n,
  input  wire logic                          run,           // high after boot load
  input  wire logic                          show_program,  // sw[0]
  input  wire logic [ghrd_pkg::NUM_KEYS-1:0] keys_pressed,
  input  wire logic                          cold_pulse,
  input  wire logic                          warm_pulse,
  input  wire logic                          debug_pulse,
  output ghrd_pkg::prog_addr_t               rd_addr,
  input  wire ghrd_pkg::prog_word_t          rd_data,
  output ghrd_pkg::prog_word_t               led
);

  import ghrd_pkg::*;

  localparam int               DIV_W    = $clog2(SCAN_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             step;         // clock enable, one cycle per period
  prog_addr_t       scan_ptr;
  logic [1:0]       cap_pipe;     // step delayed to meet rd_data
  prog_word_t       scan_word;
  prog_word_t       status_view;

  assign step = run && (div_cnt == DIV_LAST);

  // ====================
  // divider and pointer
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      scan_ptr <= '0;
    end else if (!run) begin
      div_cnt  <= '0;  // load mode, park at entry 0
      scan_ptr <= '0;
    end else if (step) begin
      div_cnt  <= '0;
      scan_ptr <= scan_ptr + 1'b1;  // 7 wraps to 0
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ====================
  // scan word capture
  // ====================
  // ptr moves at T, rd_data at T+1, capture at T+2
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      cap_pipe  <= '0;
      scan_word <= '0;
    end else begin
      cap_pipe <= {cap_pipe[0], step};
      if (cap_pipe[1]) begin
        scan_word <= rd_data;
      end
    end
  end

  assign rd_addr = scan_ptr;

  // ptr | cold warm debug | keys
  assign status_view = {scan_ptr, cold_pulse, warm_pulse, debug_pulse, keys_pressed};

  assign led = show_program ? scan_word : status_view;

endmodule

`default_nettype wire

//--- hw/reset_pulse_gen.sv
`timescale 1ns/100ps
`default_nettype none

module reset_pulse_gen #(
  parameter int PULSE_EXT = 6  // pulse length in cycles
) (
  input  wire logic fpga_clk_50,
  input  wire logic rst_n,
  input  wire logic req,    // level from the request source
  output logic      pulse   // fixed-length reset request
);

  localparam int               CNT_W    = $clog2(PULSE_EXT + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_EXT - 1);

  logic             req_q;       // request, registered once
  logic             req_dly;     // previous req_q
  logic             rise;
  logic [CNT_W-1:0] remain_cnt;  // cycles left after the current one

  assign rise = req_q & ~req_dly;

  // ====================
  // edge detect
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      req_q   <= 1'b0;
      req_dly <= 1'b0;
    end else begin
      req_q   <= req;
      req_dly <= req_q;
    end
  end

  // ====================
  // pulse stretch
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      remain_cnt <= '0;
      pulse      <= 1'b0;
    end else if (pulse) begin
      // busy, further edges dropped
      if (remain_cnt == '0) begin
        pulse <= 1'b0;
      end else begin
        remain_cnt <= remain_cnt - 1'b1;
      end
    end else if (rise) begin
      pulse      <= 1'b1;
      remain_cnt <= CNT_LOAD;  // this cycle counts as the first
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_ghrd_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ghrd_core;

  import ghrd_pkg::*;

  localparam int DEBOUNCE_TICKS = 8;
  localparam int SCAN_DIV       = 4;
  localparam int MAX_GAP        = 8;  // longest random idle gap
  localparam int DEPTH          = 1 << PROG_ADDR_W;

  logic                fpga_clk_50;
  logic                rst_n;
  logic [NUM_KEYS-1:0] key;
  logic [3:0]          sw;
  logic [2:0]          reset_req;
  logic                boot_loader_flag;
  instr_word_t         instruction;
  prog_word_t          led;
  logic                hps_cold_reset;
  logic                hps_warm_reset;
  logic                hps_debug_reset;

  // events from the vector file
  byte        cmd_q[$];
  int         a_q[$];
  int         b_q[$];
  int         c_q[$];
  prog_word_t prog_mem [DEPTH];  // words as loaded in expected scan order
  logic [NUM_KEYS-1:0] exp_keys;
  logic [31:0] rng_state = 32'h6686ffb6;
  int          budget    = 0;  // watchdog limit in cycles
  int          checks    = 0;
  int          errors    = 0;

  ghrd_core #(
    .DEBOUNCE_TICKS (DEBOUNCE_TICKS),
    .SCAN_DIV       (SCAN_DIV)
  ) dut_i (
    .fpga_clk_50      (fpga_clk_50),
    .rst_n            (rst_n),
    .key              (key),
    .sw               (sw),
    .reset_req        (reset_req),
    .boot_loader_flag (boot_loader_flag),
    .instruction      (instruction),
    .led              (led),
    .hps_cold_reset   (hps_cold_reset),
    .hps_warm_reset   (hps_warm_reset),
    .hps_debug_reset  (hps_debug_reset)
  );

  initial begin
    fpga_clk_50 = 1'b0;
    forever #20 fpga_clk_50 = ~fpga_clk_50;  // 40 ns period
  end

  // ====================
  // watchdog
  // ====================
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge fpga_clk_50);
    $display("timeout: run did not finish within %0d clock cycles", budget);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int event_budget(input byte cmd, input int a, input int b);
    case (cmd)
      "w":     return 1;
      "r":     return a * (2 * SCAN_DIV + 4) + 2;
      "g":     return b + DEBOUNCE_TICKS + 4;
      "p":     return DEBOUNCE_TICKS + 4;
      "q":     return b + 50;  // rise wait plus counting slack
      default: return 1;
    endcase
  endfunction

  function automatic logic pulse_out(input int bit_pos);
    case (bit_pos)
      RESET_KIND_COLD: return hps_cold_reset;
      RESET_KIND_WARM: return hps_warm_reset;
      default:         return hps_debug_reset;
    endcase
  endfunction

  // load mode status view with ptr 0 and no pulses
  function automatic prog_word_t status_expected();
    return {{(PROG_DATA_W-NUM_KEYS){1'b0}}, exp_keys};
  endfunction

  // ====================
  // compare tasks
  // ====================
  task automatic check_word(input prog_word_t got, input prog_word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pulse_len(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s lasted %0d cycles expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic read_vectors();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    byte   cmd;
    string line;
    fd = $fopen("testbench/tb_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open testbench/tb_input_vectors.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        a = 0;
        b = 0;
        c = 0;
        if (line.getc(0) == "w")
          n = $sscanf(line, "%c %d %h", cmd, a, b);  // data column in hex
        else
          n = $sscanf(line, "%c %d %d %d", cmd, a, b, c);
        cmd_q.push_back(cmd);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_gap();
    rng_state = lcg_next(rng_state);
    repeat (1 + rng_state[18:16]) @(negedge fpga_clk_50);
  endtask

  task automatic load_word(input int addr, input int data);
    boot_loader_flag = 1'b0;
    instruction      = {prog_addr_t'(addr), prog_word_t'(data)};
    prog_mem[addr]   = prog_word_t'(data);
    @(negedge fpga_clk_50);  // written at the posedge in between
  endtask

  task automatic scan_program(input int changes);
    prog_word_t prev;
    int         idx;
    int         waited;
    sw[0]            = 1'b1;
    boot_loader_flag = 1'b1;  // run mode
    @(negedge fpga_clk_50);
    prev = led;
    idx  = 1;  // pointer steps off 0 before the first capture
    for (int n = 0; n < changes; n++) begin
      waited = 0;
      while (led == prev && waited < 2 * SCAN_DIV + 4) begin
        @(negedge fpga_clk_50);
        waited++;
      end
      if (led == prev) begin
        errors++;
        $display("error: led stopped changing during the program scan");
        break;
      end
      check_word(led, prog_mem[idx], "scan word");
      prev = led;
      idx  = (idx + 1) % DEPTH;  // 7 wraps to 0
    end
    boot_loader_flag = 1'b0;
    sw[0]            = 1'b0;
  endtask

  // short bounce toward the other level that must not reach led
  task automatic key_glitch(input int k, input int len);
    key[k] = exp_keys[k];
    repeat (len) begin
      @(negedge fpga_clk_50);
      check_word(led, status_expected(), "key glitch");
    end
    key[k] = ~exp_keys[k];
    repeat (DEBOUNCE_TICKS + 3) begin
      @(negedge fpga_clk_50);
      check_word(led, status_expected(), "after key glitch");
    end
  endtask

  task automatic key_level(input int k, input int level);
    int waited;
    exp_keys[k] = level[0];
    key[k]      = ~level[0];  // buttons are active low
    waited      = 0;
    while (led[NUM_KEYS-1:0] != exp_keys && waited < DEBOUNCE_TICKS + 3) begin
      @(negedge fpga_clk_50);
      waited++;
    end
    if (led[NUM_KEYS-1:0] != exp_keys) begin
      errors++;
      $display("error: key %0d did not settle within %0d cycles", k, DEBOUNCE_TICKS + 3);
    end else begin
      check_word(led, status_expected(), "key level");
    end
  endtask

  task automatic reset_pulse(input int bit_pos, input int exp_len, input int retrig_at);
    int waited;
    int len;
    reset_req[bit_pos] = 1'b1;  // one cycle request
    @(negedge fpga_clk_50);
    reset_req[bit_pos] = 1'b0;
    waited = 0;
    while (!pulse_out(bit_pos) && waited < 4) begin
      @(negedge fpga_clk_50);
      waited++;
    end
    if (!pulse_out(bit_pos)) begin
      errors++;
      $display("error: reset output for request bit %0d never went high", bit_pos);
    end else begin
      len = 0;
      while (pulse_out(bit_pos) && len < exp_len + 40) begin
        len++;
        if (retrig_at != 0 && len == retrig_at)
          reset_req[bit_pos] = 1'b1;  // second edge while busy
        if (retrig_at != 0 && len == retrig_at + 1)
          reset_req[bit_pos] = 1'b0;
        @(negedge fpga_clk_50);
      end
      check_pulse_len(len, exp_len, $sformatf("reset pulse bit %0d", bit_pos));
    end
    reset_req[bit_pos] = 1'b0;
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    rst_n            = 1'b0;
    key              = '1;  // released
    sw               = '0;
    reset_req        = '0;
    boot_loader_flag = 1'b0;
    instruction      = '0;
    exp_keys         = '0;
    prog_mem         = '{default: '0};
    read_vectors();
    budget = 200;
    foreach (cmd_q[i]) budget += event_budget(cmd_q[i], a_q[i], b_q[i]) + MAX_GAP;
    repeat (2) @(negedge fpga_clk_50);
    rst_n = 1'b1;
    @(negedge fpga_clk_50);
    check_word(led, '0, "led after reset");
    check_word(prog_word_t'({hps_cold_reset, hps_warm_reset, hps_debug_reset}), '0,
               "pulses after reset");
    if (cmd_q.size() == 0) begin
      errors++;
      $display("error: no stimulus events were read");
    end
    foreach (cmd_q[i]) begin
      idle_gap();
      case (cmd_q[i])
        "w":     load_word(a_q[i], b_q[i]);
        "r":     scan_program(a_q[i]);
        "g":     key_glitch(a_q[i], b_q[i]);
        "p":     key_level(a_q[i], b_q[i]);
        "q":     reset_pulse(a_q[i], b_q[i], c_q[i]);
        default: begin
          errors++;
          $display("error: unknown event code %c in the vector file", cmd_q[i]);
        end
      endcase
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_input_vectors.txt
# w addr data_hex | r led_changes | g key cycles | p key level
# q req_bit pulse_len retrigger_cycle (0 for none)
w 0 3c
w 1 a5
w 2 5a
w 3 c3
w 4 0f
w 5 f0
w 6 96
w 7 69
r 10
g 0 5
g 1 7
p 0 1
p 0 0
p 1 1
g 0 6
p 1 0
q 0 6 0
q 1 2 0
q 2 32 0
q 2 32 10

//--- verilog.f
hw/ghrd_pkg.sv
hw/key_debounce.sv
hw/reset_pulse_gen.sv
hw/boot_program_buffer.sv
hw/program_scanner.sv
hw/ghrd_core.sv
testbench/tb_ghrd_core.sv
